/* ifu_input.txt */
# excp xret jmp jmp_target mtvec mepc ar_dly r_dly rdata rresp rdy_dly exp_pc exp_stall
# hex: jmp_target mtvec mepc rdata exp_pc; rdata "any" means a random word
0 0 1 80009000 80000f00 80000e00 0 0  00000413 0 0 80000000 0
0 0 0 00000000 00000000 00000000 1 1  any      0 0 80000004 0
0 0 0 00000000 00000000 00000000 2 3  00100093 0 2 80000008 0
0 0 1 80001000 80000f00 80000e00 0 0  0040006f 0 0 80001000 0
0 0 0 00000000 00000000 00000000 1 2  deadbeef 2 1 80001004 0
0 1 1 80002000 80000f00 80000100 0 1  30200073 0 0 80000100 0
1 1 1 80003000 80000200 80000e00 3 0  00000073 0 3 80000200 0
1 0 0 00000000 80000300 00000000 0 2  34102573 0 0 80000300 0
0 0 0 00000000 00000000 00000000 0 7  any      0 0 80000304 0
0 0 0 00000000 00000000 00000000 1 8  00a00513 0 1 80000308 1
0 0 0 00000000 00000000 00000000 0 12 cafef00d 3 0 8000030c 1
1 0 1 80005000 80000400 80000e00 2 1  fff00293 0 5 80000400 0
0 0 1 80000010 80000500 80000600 1 0  00008067 0 0 80000010 0
0 0 0 00000000 00000000 00000000 0 4  any      0 2 80000014 0

/* vlog.f */
+incdir+.
riscv_pkg.sv
ifu_pkg.sv
redirect_if.sv
fetch_fsm.sv
fetch_timer.sv
pc_gen.sv
fetch_out_buf.sv
ifu.sv
ifu_chk.sv
tb_ifu.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_ifu
FILELIST  = vlog.f
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tb_ifu.sv */
`timescale 1ns/1ps
`include "ifu_consts.svh"

module tb_ifu;

    // one fetch as read from the stimulus file
    typedef struct packed {
        logic                 excp;
        logic                 xret;
        logic                 jmp;
        riscv_pkg::addr_t     target;
        riscv_pkg::csr_data_t mtvec;
        riscv_pkg::csr_data_t mepc;
        int                   ar_dly;
        int                   r_dly;
        logic                 rdata_any;
        riscv_pkg::inst_t     rdata;
        ifu_pkg::axi_resp_t   rresp;
        int                   rdy_dly;
        riscv_pkg::addr_t     exp_pc;
        logic                 exp_stall;
    } fetch_vec_t;

    logic                 clock = 1'b0;
    logic                 reset;
    logic                 wbu_finish;
    logic                 excp_flush;
    logic                 xret_flush;
    logic                 jmp_flag;
    riscv_pkg::addr_t     jmp_target;
    riscv_pkg::csr_data_t csr_mtvec;
    riscv_pkg::csr_data_t csr_mepc;
    riscv_pkg::addr_t     araddr;
    logic                 arvalid;
    logic                 arready;
    riscv_pkg::inst_t     rdata;
    ifu_pkg::axi_resp_t   rresp;
    logic                 rvalid;
    logic                 rready;
    logic                 valid;
    logic                 ready;
    riscv_pkg::addr_t     pc;
    riscv_pkg::addr_t     snpc;
    riscv_pkg::inst_t     inst;
    logic                 fault;
    logic                 stall;

    fetch_vec_t vecs[$];
    int         value_errs = 0;
    int         proto_errs = 0;
    int         cycle_cnt = 0;
    int         cycle_limit = 0;

    ifu i_ifu (
        .clock        (clock),
        .reset        (reset),
        .wbu_finish_i (wbu_finish),
        .excp_flush_i (excp_flush),
        .xret_flush_i (xret_flush),
        .jmp_flag_i   (jmp_flag),
        .jmp_target_i (jmp_target),
        .csr_mtvec_i  (csr_mtvec),
        .csr_mepc_i   (csr_mepc),
        .araddr_o     (araddr),
        .arvalid_o    (arvalid),
        .arready_i    (arready),
        .rdata_i      (rdata),
        .rresp_i      (rresp),
        .rvalid_i     (rvalid),
        .rready_o     (rready),
        .valid_o      (valid),
        .ready_i      (ready),
        .pc_o         (pc),
        .snpc_o       (snpc),
        .inst_o       (inst),
        .fault_o      (fault),
        .stall_o      (stall)
    );

    always #50 clock = ~clock;

    // watchdog on the whole run
    always @(posedge clock) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: the fetch unit hung after %0d cycles", cycle_cnt);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic step();
        @(posedge clock);
        #1;
    endtask

    task automatic report_mismatch(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        value_errs++;
    endtask

    task automatic report_protocol(input string msg);
        $display("protocol problem at %0t ns: %s", $time, msg);
        proto_errs++;
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        int          f_excp;
        int          f_xret;
        int          f_jmp;
        int          f_ar;
        int          f_r;
        int          f_rresp;
        int          f_rdy;
        int          f_stall;
        logic [31:0] f_target;
        logic [31:0] f_mtvec;
        logic [31:0] f_mepc;
        logic [31:0] f_pc;
        string       f_rdata;
        string       line;
        fetch_vec_t  v;
        cycle_limit = 10;
        fd = $fopen("ifu_input.txt", "r");
        if (fd == 0) begin
            report_protocol("could not open ifu_input.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%d %d %d %h %h %h %d %d %s %d %d %h %d",
                        f_excp, f_xret, f_jmp, f_target, f_mtvec, f_mepc,
                        f_ar, f_r, f_rdata, f_rresp, f_rdy, f_pc, f_stall);
            if (n != 13) begin
                report_protocol($sformatf("bad stimulus line: %s", line));
                continue;
            end
            v.excp      = (f_excp != 0);
            v.xret      = (f_xret != 0);
            v.jmp       = (f_jmp != 0);
            v.target    = f_target;
            v.mtvec     = f_mtvec;
            v.mepc      = f_mepc;
            v.ar_dly    = f_ar;
            v.r_dly     = f_r;
            v.rdata_any = (f_rdata == "any");
            v.rdata     = v.rdata_any ? '0 : f_rdata.atohex();
            v.rresp     = ifu_pkg::axi_resp_t'(f_rresp);
            v.rdy_dly   = f_rdy;
            v.exp_pc    = f_pc;
            v.exp_stall = (f_stall != 0);
            vecs.push_back(v);
            cycle_limit += 40 + f_ar + f_r + f_rdy;
        end
        $fclose(fd);
        if (vecs.size() == 0) begin
            report_protocol("no fetches found in ifu_input.txt");
        end
    endtask

    task automatic run_fetch(input fetch_vec_t v, input int idx);
        riscv_pkg::inst_t word;
        riscv_pkg::addr_t pkt_pc;
        riscv_pkg::inst_t pkt_inst;
        logic             pkt_fault;
        logic             exp_fault;
        logic             stall_seen;
        word       = v.rdata_any ? riscv_pkg::inst_t'($urandom) : v.rdata;
        exp_fault  = (v.rresp != `IFU_AXI_OKAY);
        stall_seen = 1'b0;
        if (arvalid || valid) begin
            report_protocol($sformatf("line %0d: unit not idle before finish", idx));
        end
        // retire pulse with this line's redirect request
        wbu_finish = 1'b1;
        excp_flush = v.excp;
        xret_flush = v.xret;
        jmp_flag   = v.jmp;
        jmp_target = v.target;
        csr_mtvec  = v.mtvec;
        csr_mepc   = v.mepc;
        step();
        wbu_finish = 1'b0;
        while (!arvalid) step();
        if (araddr !== v.exp_pc) begin
            report_mismatch($sformatf("line %0d: araddr %h, expected %h", idx, araddr, v.exp_pc));
        end
        // slave address phase
        repeat (v.ar_dly) step();
        arready = 1'b1;
        step();
        arready = 1'b0;
        if (arvalid) begin
            report_protocol($sformatf("line %0d: arvalid high after AR handshake", idx));
        end
        if (!rready) begin
            report_protocol($sformatf("line %0d: rready low after AR handshake", idx));
        end
        while (!rready) step();
        repeat (v.r_dly) begin
            step();
            stall_seen |= stall;
        end
        rvalid = 1'b1;
        rdata  = word;
        rresp  = v.rresp;
        step();
        rvalid = 1'b0;
        if (rready) begin
            report_protocol($sformatf("line %0d: rready high after R handshake", idx));
        end
        if (stall) begin
            report_mismatch($sformatf("line %0d: stall high after R handshake", idx));
        end
        if (stall_seen !== v.exp_stall) begin
            report_mismatch($sformatf("line %0d: stall seen %b, expected %b",
                                      idx, stall_seen, v.exp_stall));
        end
        while (!valid) step();
        if (pc !== v.exp_pc || snpc !== v.exp_pc + `IFU_PC_STEP) begin
            report_mismatch($sformatf("line %0d: pc %h snpc %h, expected pc %h",
                                      idx, pc, snpc, v.exp_pc));
        end
        if (inst !== word || fault !== exp_fault) begin
            report_mismatch($sformatf("line %0d: inst %h fault %b, expected %h %b",
                                      idx, inst, fault, word, exp_fault));
        end
        pkt_pc    = pc;
        pkt_inst  = inst;
        pkt_fault = fault;
        // decode holds off
        repeat (v.rdy_dly) begin
            step();
            if (!valid || pc !== pkt_pc || inst !== pkt_inst || fault !== pkt_fault) begin
                report_mismatch($sformatf("line %0d: packet changed under back-pressure", idx));
            end
            if (arvalid) begin
                report_protocol($sformatf("line %0d: arvalid without finish", idx));
            end
        end
        ready = 1'b1;
        step();
        ready = 1'b0;
        if (valid) begin
            report_protocol($sformatf("line %0d: valid_o high after decode took it", idx));
        end
    endtask

    initial begin
        int seed_val;
        seed_val   = $urandom(32'h6704_9efd);
        reset      = 1'b1;
        wbu_finish = 1'b0;
        excp_flush = 1'b0;
        xret_flush = 1'b0;
        jmp_flag   = 1'b0;
        jmp_target = '0;
        csr_mtvec  = '0;
        csr_mepc   = '0;
        arready    = 1'b0;
        rdata      = '0;
        rresp      = '0;
        rvalid     = 1'b0;
        ready      = 1'b0;
        load_vectors();
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;
        if (arvalid || rready || valid || stall) begin
            report_mismatch("outputs not low after reset");
        end
        foreach (vecs[i]) begin
            run_fetch(vecs[i], i + 1);
        end
        $display("value errors: %0d, protocol errors: %0d", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* ifu_chk.sv */
`timescale 1ns/1ps

module ifu_chk (
    input logic             clock,
    input logic             reset,
    input riscv_pkg::addr_t araddr_i,
    input logic             arvalid_i,
    input logic             arready_i,
    input logic             rready_i,
    input logic             valid_i,
    input logic             ready_i,
    input riscv_pkg::addr_t pc_i,
    input riscv_pkg::addr_t snpc_i,
    input riscv_pkg::inst_t inst_i,
    input logic             fault_i
);

    // AR request holds until accepted
    a_ar_hold: assert property (@(posedge clock) disable iff (reset)
        arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
        else $error("arvalid or araddr changed before arready");

    // packet toward decode holds until ready
    a_pkt_hold: assert property (@(posedge clock) disable iff (reset)
        valid_i && !ready_i |=> valid_i && $stable(pc_i) && $stable(snpc_i)
            && $stable(inst_i) && $stable(fault_i))
        else $error("decode packet changed before ready");

    a_ar_r_excl: assert property (@(posedge clock) disable iff (reset)
        !(arvalid_i && rready_i))
        else $error("arvalid and rready high together");

endmodule

bind ifu ifu_chk i_ifu_chk (
    .clock     (clock),
    .reset     (reset),
    .araddr_i  (araddr_o),
    .arvalid_i (arvalid_o),
    .arready_i (arready_i),
    .rready_i  (rready_o),
    .valid_i   (valid_o),
    .ready_i   (ready_i),
    .pc_i      (pc_o),
    .snpc_i    (snpc_o),
    .inst_i    (inst_o),
    .fault_i   (fault_o)
);

/* ifu.sv */
`timescale 1ns/1ps

module ifu (
    input  logic                 clock,
    input  logic                 reset,
    // write-back redirect
    input  logic                 wbu_finish_i,
    input  logic                 excp_flush_i,
    input  logic                 xret_flush_i,
    input  logic                 jmp_flag_i,
    input  riscv_pkg::addr_t     jmp_target_i,
    input  riscv_pkg::csr_data_t csr_mtvec_i,
    input  riscv_pkg::csr_data_t csr_mepc_i,
    // axi4-lite read address
    output riscv_pkg::addr_t     araddr_o,
    output logic                 arvalid_o,
    input  logic                 arready_i,
    // axi4-lite read data
    input  riscv_pkg::inst_t     rdata_i,
    input  ifu_pkg::axi_resp_t   rresp_i,
    input  logic                 rvalid_i,
    output logic                 rready_o,
    // decode
    output logic                 valid_o,
    input  logic                 ready_i,
    output riscv_pkg::addr_t     pc_o,
    output riscv_pkg::addr_t     snpc_o,
    output riscv_pkg::inst_t     inst_o,
    output logic                 fault_o,
    output logic                 stall_o
);

    redirect_if redir ();

    logic             pc_advance;
    logic             wait_active;
    logic             capture;
    riscv_pkg::addr_t fetch_pc;
    riscv_pkg::addr_t fetch_snpc;

    assign redir.finish     = wbu_finish_i;
    assign redir.excp_flush = excp_flush_i;
    assign redir.xret_flush = xret_flush_i;
    assign redir.jmp_flag   = jmp_flag_i;
    assign redir.jmp_target = jmp_target_i;

    // the current pc is the read address
    assign araddr_o = fetch_pc;

    fetch_fsm i_fetch_fsm (
        .clock         (clock),
        .reset         (reset),
        .redir         (redir.fsm),
        .arready_i     (arready_i),
        .rvalid_i      (rvalid_i),
        .ready_i       (ready_i),
        .arvalid_o     (arvalid_o),
        .rready_o      (rready_o),
        .valid_o       (valid_o),
        .pc_advance_o  (pc_advance),
        .wait_active_o (wait_active),
        .capture_o     (capture)
    );

    fetch_timer i_fetch_timer (
        .clock         (clock),
        .reset         (reset),
        .wait_active_i (wait_active),
        .stall_o       (stall_o)
    );

    pc_gen i_pc_gen (
        .clock        (clock),
        .reset        (reset),
        .redir        (redir.pcgen),
        .csr_mtvec_i  (csr_mtvec_i),
        .csr_mepc_i   (csr_mepc_i),
        .pc_advance_i (pc_advance),
        .pc_o         (fetch_pc),
        .snpc_o       (fetch_snpc)
    );

    fetch_out_buf i_fetch_out_buf (
        .clock     (clock),
        .reset     (reset),
        .capture_i (capture),
        .pc_i      (fetch_pc),
        .snpc_i    (fetch_snpc),
        .rdata_i   (rdata_i),
        .rresp_i   (rresp_i),
        .pc_o      (pc_o),
        .snpc_o    (snpc_o),
        .inst_o    (inst_o),
        .fault_o   (fault_o)
    );

endmodule

/* fetch_out_buf.sv */
`timescale 1ns/1ps
`include "ifu_consts.svh"

module fetch_out_buf (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 capture_i,
    input  riscv_pkg::addr_t     pc_i,
    input  riscv_pkg::addr_t     snpc_i,
    input  riscv_pkg::inst_t     rdata_i,
    input  ifu_pkg::axi_resp_t   rresp_i,
    output riscv_pkg::addr_t     pc_o,
    output riscv_pkg::addr_t     snpc_o,
    output riscv_pkg::inst_t     inst_o,
    output logic                 fault_o
);

    riscv_pkg::addr_t pc_q;
    riscv_pkg::addr_t snpc_q;
    riscv_pkg::inst_t inst_q;
    logic             fault_q;

    // packet changes only on the R handshake
    always_ff @(posedge clock) begin
        if (reset) begin
            pc_q    <= '0;
            snpc_q  <= '0;
            inst_q  <= '0;
            fault_q <= 1'b0;
        end else if (capture_i) begin
            pc_q    <= pc_i;
            snpc_q  <= snpc_i;
            inst_q  <= rdata_i;
            // slverr or decerr marks a bus fault
            fault_q <= (rresp_i != ifu_pkg::axi_resp_t'(`IFU_AXI_OKAY));
        end
    end

    assign pc_o    = pc_q;
    assign snpc_o  = snpc_q;
    assign inst_o  = inst_q;
    assign fault_o = fault_q;

endmodule

/* pc_gen.sv */
`timescale 1ns/1ps
`include "ifu_consts.svh"

module pc_gen (
    input  logic                 clock,
    input  logic                 reset,
    redirect_if.pcgen            redir,
    input  riscv_pkg::csr_data_t csr_mtvec_i,
    input  riscv_pkg::csr_data_t csr_mepc_i,
    input  logic                 pc_advance_i,
    output riscv_pkg::addr_t     pc_o,
    output riscv_pkg::addr_t     snpc_o
);

    riscv_pkg::addr_t pc;
    riscv_pkg::addr_t dnpc;
    logic             started;

    assign snpc_o = pc + riscv_pkg::addr_t'(`IFU_PC_STEP);

    // exception wins over xret, xret over jump
    always_comb begin
        if (redir.excp_flush) begin
            dnpc = csr_mtvec_i;
        end else if (redir.xret_flush) begin
            dnpc = csr_mepc_i;
        end else if (redir.jmp_flag) begin
            dnpc = redir.jmp_target;
        end else begin
            dnpc = snpc_o;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc      <= riscv_pkg::addr_t'(`IFU_RESET_PC);
            started <= 1'b0;
        end else if (pc_advance_i) begin
            started <= 1'b1;
            // first fetch reads the reset pc itself
            if (started) begin
                pc <= dnpc;
            end
        end
    end

    assign pc_o = pc;

endmodule

/* fetch_timer.sv */
`timescale 1ns/1ps
`include "ifu_consts.svh"

module fetch_timer (
    input  logic clock,
    input  logic reset,
    input  logic wait_active_i,
    output logic stall_o
);

    localparam ifu_pkg::wait_cnt_t CNT_MAX   = '1;
    localparam ifu_pkg::wait_cnt_t CNT_LIMIT = ifu_pkg::wait_cnt_t'(`IFU_STALL_LIMIT);

    ifu_pkg::wait_cnt_t wait_cnt;

    always_ff @(posedge clock) begin
        if (reset) begin
            wait_cnt <= '0;
        end else if (!wait_active_i) begin
            // response arrived or no read pending
            wait_cnt <= '0;
        end else if (wait_cnt != CNT_MAX) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // status only, the read keeps going
    assign stall_o = (wait_cnt >= CNT_LIMIT);

endmodule

/* fetch_fsm.sv */
`timescale 1ns/1ps

module fetch_fsm (
    input  logic    clock,
    input  logic    reset,
    redirect_if.fsm redir,
    input  logic    arready_i,
    input  logic    rvalid_i,
    input  logic    ready_i,
    output logic    arvalid_o,
    output logic    rready_o,
    output logic    valid_o,
    output logic    pc_advance_o,
    output logic    wait_active_o,
    output logic    capture_o
);

    ifu_pkg::fetch_state_e state;
    ifu_pkg::fetch_state_e state_next;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= ifu_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        unique case (state)
            ifu_pkg::IDLE: begin
                // finish outside idle is dropped
                if (redir.finish) begin
                    state_next = ifu_pkg::ADDR;
                end
            end
            ifu_pkg::ADDR: begin
                if (arready_i) begin
                    state_next = ifu_pkg::RESP;
                end
            end
            ifu_pkg::RESP: begin
                if (rvalid_i) begin
                    state_next = ifu_pkg::HOLD;
                end
            end
            ifu_pkg::HOLD: begin
                // wait for decode to take the packet
                if (ready_i) begin
                    state_next = ifu_pkg::IDLE;
                end
            end
            default: begin
                state_next = ifu_pkg::IDLE;
            end
        endcase
    end

    // handshake outputs straight from state
    assign arvalid_o = (state == ifu_pkg::ADDR);
    assign rready_o  = (state == ifu_pkg::RESP);
    assign valid_o   = (state == ifu_pkg::HOLD);

    // one-cycle strobes
    assign pc_advance_o  = (state == ifu_pkg::IDLE) && redir.finish;
    assign capture_o     = (state == ifu_pkg::RESP) && rvalid_i;
    // still waiting on R
    assign wait_active_o = (state == ifu_pkg::RESP) && !rvalid_i;

endmodule

/* redirect_if.sv */
`timescale 1ns/1ps

interface redirect_if;

    // instruction retired in write-back
    logic               finish;
    // redirect request, valid together with finish
    logic               excp_flush;
    logic               xret_flush;
    logic               jmp_flag;
    riscv_pkg::addr_t   jmp_target;

    modport fsm (
        input finish
    );

    modport pcgen (
        input excp_flush,
        input xret_flush,
        input jmp_flag,
        input jmp_target
    );

endinterface

/* ifu_pkg.sv */
package ifu_pkg;

    // fetch sequencing states
    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        RESP,
        HOLD
    } fetch_state_e;

    // axi read response code
    typedef logic [1:0] axi_resp_t;

    // response-wait counter
    typedef logic [3:0] wait_cnt_t;

endpackage

/* riscv_pkg.sv */
`include "ifu_consts.svh"

package riscv_pkg;

    // instruction address
    typedef logic [`IFU_XLEN-1:0] addr_t;

    // raw instruction word
    typedef logic [`IFU_XLEN-1:0] inst_t;

    // csr value, mtvec and mepc
    typedef logic [`IFU_XLEN-1:0] csr_data_t;

endpackage

/* ifu_consts.svh */
`ifndef IFU_CONSTS_SVH
`define IFU_CONSTS_SVH

// architectural data width
`define IFU_XLEN 32

// first fetch address after reset
`define IFU_RESET_PC 32'h8000_0000

// sequential pc increment
`define IFU_PC_STEP 32'd4

// response-wait cycles before stall is reported
`define IFU_STALL_LIMIT 8

// axi response code for a good transfer
`define IFU_AXI_OKAY 2'b00

`endif
